// ==== source/esp_mmio_pkg.sv ====
package esp_mmio_pkg;

  // CPU side Wishbone classic request, 71 bits
  typedef struct packed {
    logic [31:0] adr;  // Byte address
    logic [31:0] dat;  // Write data
    logic [3:0]  sel;  // Byte lane enables
    logic        we;   // High for a write
    logic        stb;  // Strobe, raised with cyc
    logic        cyc;  // Bus cycle in progress
  } wb_req_t;

  // Wishbone response back to the master
  typedef struct packed {
    logic [31:0] dat;  // Read data, valid with ack
    logic        ack;  // Single cycle acknowledge
  } wb_rsp_t;

  // One register write from the ESP32 receiver
  typedef struct packed {
    logic        valid;  // Single cycle write strobe
    logic [4:0]  idx;    // Target register
    logic [31:0] data;   // Assembled word, MSB byte first on the wire
  } reg_wr_t;

  // Address map
  // RAM sits at the bottom of the space and must stay below the register window,
  // so RAM_WORDS is limited to 256 words
  localparam logic [31:0] RAM_BASE = 32'h0000_0000;

  // Register window, 32 words from 0x400 up to 0x47F
  // Address bits 6:2 pick the register
  localparam logic [31:0] REG_BASE = 32'h0000_0400;

  // Number of external registers
  localparam int REG_COUNT = 32;

  // Anything outside RAM and the register window is unmapped
  // and reads back as zero

endpackage

// ==== source/esp_byte_receiver.sv ====
`timescale 1ns/1ns
`default_nettype none

module esp_byte_receiver (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [7:0]            esp_data,   // Byte from the ESP32
  input  logic                  esp_valid,  // One cycle per byte
  input  logic                  esp_frame,  // High with the index byte
  output esp_mmio_pkg::reg_wr_t reg_wr,     // To the external register file
  output logic                  esp_busy    // Frame in progress
);

  import esp_mmio_pkg::*;

  localparam int IDX_W = $clog2(REG_COUNT);

  // Frame control
  logic             busy_q;     // Index seen, data bytes pending
  logic [1:0]       data_cnt;   // Data bytes taken so far
  logic             idx_byte;   // Current byte starts a frame
  logic             take_data;  // Current byte is a data byte
  logic             last_byte;  // Fourth data byte

  // Frame payload
  logic [IDX_W-1:0] idx_q;      // Captured register index
  logic [23:0]      acc_q;      // First three data bytes, shifted in MSB first

  // Outgoing write
  logic             wr_valid_q;
  logic [IDX_W-1:0] wr_idx_q;
  logic [31:0]      wr_data_q;

  // An index byte always wins, even in the middle of a frame
  assign idx_byte  = esp_valid && esp_frame;
  assign take_data = esp_valid && !esp_frame && busy_q; // Stray bytes while idle are dropped
  assign last_byte = take_data && (data_cnt == 2'd3);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      data_cnt   <= '0;
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= last_byte; // One pulse per completed frame
      if (idx_byte) begin
        busy_q   <= 1'b1;
        data_cnt <= '0;        // Partial frame discarded
      end else if (take_data) begin
        data_cnt <= data_cnt + 2'd1; // Wraps back to zero on the last byte
        if (last_byte) begin
          busy_q <= 1'b0;      // Falls with the write
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (idx_byte) begin
      idx_q <= esp_data[IDX_W-1:0]; // Upper index bits ignored
    end
    if (take_data) begin
      acc_q <= {acc_q[15:0], esp_data};
    end
    if (last_byte) begin
      wr_idx_q  <= idx_q;
      wr_data_q <= {acc_q, esp_data}; // Last byte is the LSB
    end
  end

  assign reg_wr   = '{valid: wr_valid_q, idx: wr_idx_q, data: wr_data_q};
  assign esp_busy = busy_q;

  // Back to back frames need at least five bytes, so writes never touch
  a_wr_single : assert property (@(posedge clk) disable iff (!rst_n)
    wr_valid_q |=> !wr_valid_q);

endmodule

`default_nettype wire

// ==== source/ext_register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module ext_register_file (
  input  logic                  clk,
  input  logic                  rst_n,
  input  esp_mmio_pkg::reg_wr_t reg_wr,   // Write port from the receiver
  input  logic                  rd_stb,   // Read request from the decoder
  input  logic [4:0]            rd_idx,   // Register to read
  output logic [31:0]           rd_data,  // Valid with rd_ack
  output logic                  rd_ack
);

  import esp_mmio_pkg::*;

  logic [31:0] regs [REG_COUNT]; // External register array
  logic [31:0] rd_data_q;
  logic        rd_ack_q;
  logic        rd_take;          // Read accepted this cycle

  // Write side, owned by the ESP32 receiver
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wr.valid) begin
      regs[reg_wr.idx] <= reg_wr.data;
    end
  end

  // Strobe is held until ack, so only the first sampled cycle counts
  assign rd_take = rd_stb && !rd_ack_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ack_q <= 1'b0;
    end else begin
      rd_ack_q <= rd_take; // Drops again the cycle after
    end
  end

  // A write landing on the same edge shows up on the next read
  always_ff @(posedge clk) begin
    if (rd_take) begin
      rd_data_q <= regs[rd_idx];
    end
  end

  assign rd_data = rd_data_q;
  assign rd_ack  = rd_ack_q;

  // Ack must be the answer to a strobe from the decoder
  a_ack_after_stb : assert property (@(posedge clk) disable iff (!rst_n)
    rd_ack |-> $past(rd_stb));

endmodule

`default_nettype wire

// ==== source/mmio_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmio_decoder #(
  parameter int RAM_WORDS = 256
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  esp_mmio_pkg::wb_req_t cpu_req,  // From the CPU
  output esp_mmio_pkg::wb_rsp_t cpu_rsp,
  output esp_mmio_pkg::wb_req_t ram_req,  // Toward the data RAM
  input  esp_mmio_pkg::wb_rsp_t ram_rsp,
  output logic                  rd_stb,   // Toward the register file
  output logic [4:0]            rd_idx,
  input  logic [31:0]           rd_data,
  input  logic                  rd_ack
);

  import esp_mmio_pkg::*;

  localparam logic [31:0] RAM_BYTES = 32'(RAM_WORDS * 4);
  localparam logic [31:0] REG_BYTES = 32'(REG_COUNT * 4);

  // RAM has to end below the register window
  if (RAM_WORDS > 256) begin : g_ram_size_check
    $error("RAM_WORDS %0d overlaps the register window", RAM_WORDS);
  end

  logic        req;          // Active bus cycle
  logic [31:0] ram_off;      // Offset into the RAM region
  logic [31:0] reg_off;      // Offset into the register window
  logic        in_ram;
  logic        in_reg;
  logic        local_hit;    // Access answered here
  logic        local_ack_q;

  assign req     = cpu_req.cyc && cpu_req.stb;
  assign ram_off = cpu_req.adr - RAM_BASE;
  assign reg_off = cpu_req.adr - REG_BASE;
  assign in_ram  = ram_off < RAM_BYTES;   // Wraps high below the base
  assign in_reg  = reg_off < REG_BYTES;

  // RAM region, forwarded as is with a local address
  always_comb begin
    ram_req     = cpu_req;
    ram_req.adr = ram_off;
    ram_req.stb = cpu_req.stb && in_ram;
  end

  // Register window is read only from the CPU
  assign rd_stb = req && in_reg && !cpu_req.we;
  assign rd_idx = reg_off[6:2];

  // Dropped register writes and unmapped space
  assign local_hit = req && ((in_reg && cpu_req.we) || (!in_ram && !in_reg));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      local_ack_q <= 1'b0;
    end else begin
      local_ack_q <= local_hit && !local_ack_q; // Same single cycle ack as the slaves
    end
  end

  // Only one source acks at a time, so the acks steer the data
  always_comb begin
    cpu_rsp.ack = ram_rsp.ack || rd_ack || local_ack_q;
    if (ram_rsp.ack) begin
      cpu_rsp.dat = ram_rsp.dat;
    end else if (rd_ack) begin
      cpu_rsp.dat = rd_data;
    end else begin
      cpu_rsp.dat = '0; // Local acks read zero
    end
  end

  // Regions never overlap
  a_one_strobe : assert property (@(posedge clk) disable iff (!rst_n)
    !(ram_req.stb && rd_stb));

  // RAM, register file and local ack never answer together
  a_one_ack_source : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({ram_rsp.ack, rd_ack, local_ack_q}));

  // Whatever region answered, the CPU sees a one cycle ack
  a_cpu_ack_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    cpu_rsp.ack |=> !cpu_rsp.ack);

endmodule

`default_nettype wire

// ==== source/data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  esp_mmio_pkg::wb_req_t ram_req,  // Strobe already gated by the decoder
  output esp_mmio_pkg::wb_rsp_t ram_rsp
);

  localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  logic [31:0]   mem [RAM_WORDS];
  logic [AW-1:0] word_idx;    // Word address, byte offset dropped
  logic          hit;         // Request accepted this cycle
  logic          ack_q;
  logic [31:0]   rdat_q;

  assign word_idx = ram_req.adr[AW+1:2];
  assign hit      = ram_req.cyc && ram_req.stb && !ack_q;

  // Byte lane writes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < RAM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (hit && ram_req.we) begin
      for (int b = 0; b < 4; b++) begin
        if (ram_req.sel[b]) begin
          mem[word_idx][8*b +: 8] <= ram_req.dat[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;
    end
  end

  always_ff @(posedge clk) begin
    if (hit && !ram_req.we) begin
      rdat_q <= mem[word_idx];
    end
  end

  assign ram_rsp = '{dat: rdat_q, ack: ack_q};

  a_ack_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    ack_q |=> !ack_q);

endmodule

`default_nettype wire

// ==== source/esp_mmio_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module esp_mmio_top #(
  parameter int RAM_WORDS = 256  // Power of two, at most 256
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // CPU side, Wishbone classic
  input  esp_mmio_pkg::wb_req_t cpu_req,
  output esp_mmio_pkg::wb_rsp_t cpu_rsp,

  // ESP32 byte bus
  input  logic [7:0]            esp_data,
  input  logic                  esp_valid,
  input  logic                  esp_frame,
  output logic                  esp_busy
);

  import esp_mmio_pkg::*;

  reg_wr_t     reg_wr;   // Receiver to register file
  wb_req_t     ram_req;  // Decoder to RAM
  wb_rsp_t     ram_rsp;
  logic        rd_stb;   // Decoder to register file
  logic [4:0]  rd_idx;
  logic [31:0] rd_data;
  logic        rd_ack;

  // ESP32 frames into register writes
  esp_byte_receiver u_esp_byte_receiver (
    .clk       (clk),
    .rst_n     (rst_n),
    .esp_data  (esp_data),
    .esp_valid (esp_valid),
    .esp_frame (esp_frame),
    .reg_wr    (reg_wr),
    .esp_busy  (esp_busy)
  );

  ext_register_file u_ext_register_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .reg_wr  (reg_wr),
    .rd_stb  (rd_stb),
    .rd_idx  (rd_idx),
    .rd_data (rd_data),
    .rd_ack  (rd_ack)
  );

  // CPU address decode
  mmio_decoder #(
    .RAM_WORDS (RAM_WORDS)
  ) u_mmio_decoder (
    .clk     (clk),
    .rst_n   (rst_n),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp),
    .rd_stb  (rd_stb),
    .rd_idx  (rd_idx),
    .rd_data (rd_data),
    .rd_ack  (rd_ack)
  );

  data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_data_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .ram_req (ram_req),
    .ram_rsp (ram_rsp)
  );

endmodule

`default_nettype wire

// ==== bench/tb_esp_mmio.sv ====
`timescale 1ns/1ns

module tb_esp_mmio;

  import esp_mmio_pkg::*;

  localparam int RAM_WORDS  = 256;
  localparam int CLK_PERIOD = 100;
  localparam int N_OPS      = 200; // Bus accesses and frames, rounded up

  logic        clk = 1'b0;
  logic        rst_n;
  wb_req_t     cpu_req;
  wb_rsp_t     cpu_rsp;
  logic [7:0]  esp_data;
  logic        esp_valid;
  logic        esp_frame;
  logic        esp_busy;

  logic [31:0] reg_model [REG_COUNT];  // Expected external registers
  logic [31:0] ram_model [RAM_WORDS];  // Expected RAM contents
  logic [31:0] exp_dat;                // Read data due with the next ack
  logic        chk_read;               // Access in flight is a read
  logic        busy_exp;               // Receiver state after the last byte
  logic [15:0] lfsr = 16'd42790;
  logic        req_on;

  esp_mmio_top #(
    .RAM_WORDS (RAM_WORDS)
  ) u_esp_mmio_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_req   (cpu_req),
    .cpu_rsp   (cpu_rsp),
    .esp_data  (esp_data),
    .esp_valid (esp_valid),
    .esp_frame (esp_frame),
    .esp_busy  (esp_busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  assign req_on = cpu_req.cyc && cpu_req.stb;

  task automatic report_fail();
    $display("tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] dat,
                                              input logic [3:0] sel);
    logic [31:0] m;
    m = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) m[8*b +: 8] = dat[8*b +: 8]; // Only enabled lanes change
    end
    return m;
  endfunction

  function automatic logic [31:0] reg_adr(input logic [4:0] idx);
    return REG_BASE + {25'h0, idx, 2'b00};
  endfunction

  // Holds the request until ack, then releases the bus
  task automatic wait_ack();
    do begin
      @(posedge clk);
      #5;
    end while (!cpu_rsp.ack);
    cpu_req.stb = 1'b0;
    cpu_req.cyc = 1'b0;
    cpu_req.we  = 1'b0;
  endtask

  task automatic wb_read(input logic [31:0] adr, input logic [31:0] expected);
    @(posedge clk); // One idle edge between accesses
    #5;
    exp_dat  = expected;
    chk_read = 1'b1;
    cpu_req  = '{adr: adr, dat: 32'h0, sel: 4'hf, we: 1'b0, stb: 1'b1, cyc: 1'b1};
    wait_ack();
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    @(posedge clk);
    #5;
    chk_read = 1'b0;
    cpu_req  = '{adr: adr, dat: dat, sel: sel, we: 1'b1, stb: 1'b1, cyc: 1'b1};
    wait_ack();
  endtask

  task automatic send_byte(input logic [7:0] b, input logic frame, input logic busy_after);
    esp_data  = b;
    esp_valid = 1'b1;
    esp_frame = frame;
    @(posedge clk);
    #5;
    esp_valid = 1'b0;
    esp_frame = 1'b0;
    busy_exp  = busy_after;
  endtask

  // Index byte and nbytes data bytes MSB first, four bytes complete the frame
  task automatic send_frame(input logic [4:0] idx, input logic [31:0] data, input int nbytes);
    send_byte({3'(rand_bits(3)), idx}, 1'b1, 1'b1); // Upper index bits ignored by the DUT
    for (int b = 0; b < nbytes; b++) begin
      send_byte(data[8*(3-b) +: 8], 1'b0, b != 3);
    end
    if (nbytes == 4) reg_model[idx] = data;
  endtask

  a_read_data : assert property (@(posedge clk) disable iff (!rst_n)
    (cpu_rsp.ack && chk_read) |-> cpu_rsp.dat == exp_dat)
    else begin
      $display("CHECK FAILED cpu_rsp.dat adr %h expected %h actual %h",
               $sampled(cpu_req.adr), $sampled(exp_dat), $sampled(cpu_rsp.dat));
      report_fail();
    end

  a_ack_next : assert property (@(posedge clk) disable iff (!rst_n)
    (req_on && !cpu_rsp.ack) |=> cpu_rsp.ack)
    else begin
      $display("CHECK FAILED cpu_rsp.ack expected %h actual %h", 1'b1, $sampled(cpu_rsp.ack));
      report_fail();
    end

  a_ack_single : assert property (@(posedge clk) disable iff (!rst_n)
    cpu_rsp.ack |=> !cpu_rsp.ack)
    else begin
      $display("CHECK FAILED cpu_rsp.ack expected %h actual %h", 1'b0, $sampled(cpu_rsp.ack));
      report_fail();
    end

  a_ack_req : assert property (@(posedge clk) disable iff (!rst_n)
    cpu_rsp.ack |-> $past(req_on))
    else begin
      $display("Ack arrived without a bus request in the cycle before");
      report_fail();
    end

  a_busy : assert property (@(posedge clk) disable iff (!rst_n)
    esp_busy == busy_exp)
    else begin
      $display("CHECK FAILED esp_busy expected %h actual %h", $sampled(busy_exp),
               $sampled(esp_busy));
      report_fail();
    end

  initial begin : watchdog
    #((N_OPS * 20 + 100) * CLK_PERIOD);
    $display("Timeout, the run did not finish within %0d clock periods", N_OPS * 20 + 100);
    report_fail();
  end

  initial begin : main
    logic [4:0]  p;
    logic [4:0]  q;
    logic [7:0]  w;
    logic [31:0] d;
    logic [3:0]  s;
    rst_n     = 1'b0;
    cpu_req   = '0;
    esp_data  = '0;
    esp_valid = 1'b0;
    esp_frame = 1'b0;
    exp_dat   = '0;
    chk_read  = 1'b0;
    busy_exp  = 1'b0;
    for (int i = 0; i < REG_COUNT; i++) reg_model[i] = '0;
    for (int i = 0; i < RAM_WORDS; i++) ram_model[i] = '0;
    repeat (8) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // Everything reads zero out of reset
    for (int i = 0; i < REG_COUNT; i++) wb_read(reg_adr(5'(i)), reg_model[i]);
    for (int i = 0; i < RAM_WORDS; i += 8) wb_read(32'(i * 4), ram_model[i]);

    // Complete frames
    for (int it = 0; it < 8; it++) begin
      p = 5'(rand_bits(5));
      send_frame(p, rand_bits(32), 4);
      wb_read(reg_adr(p), reg_model[p]);
    end

    // Frames cut short by a new index byte, same or next register
    for (int it = 0; it < 4; it++) begin
      p = 5'(rand_bits(5));
      q = it[0] ? p : p + 5'd1;
      send_frame(p, rand_bits(32), it);
      send_frame(q, rand_bits(32), 4);
      wb_read(reg_adr(p), reg_model[p]);
      wb_read(reg_adr(q), reg_model[q]);
    end
    send_byte(8'(rand_bits(8)), 1'b0, 1'b0); // Stray data byte while idle
    for (int i = 0; i < REG_COUNT; i++) wb_read(reg_adr(5'(i)), reg_model[i]);

    // RAM byte lanes, small word range so lanes merge
    for (int it = 0; it < 24; it++) begin
      w = 8'(rand_bits(4));
      d = rand_bits(32);
      s = 4'(rand_bits(4));
      wb_write({22'h0, w, 2'b00}, d, s);
      ram_model[w] = merge_lanes(ram_model[w], d, s);
      wb_read({22'h0, w, 2'b00}, ram_model[w]);
    end

    // CPU writes to the register window are dropped
    for (int it = 0; it < 4; it++) begin
      p = 5'(rand_bits(5));
      wb_write(reg_adr(p), rand_bits(32), 4'hf);
      wb_read(reg_adr(p), reg_model[p]);
    end

    // Unmapped space
    wb_read(32'h0000_0480, 32'h0);
    wb_read(32'h0000_1000, 32'h0);
    wb_read(32'hFFFF_FFFC, 32'h0);
    wb_write(32'h0000_0480, rand_bits(32), 4'hf);
    wb_write(32'h8000_0000, rand_bits(32), 4'hf);
    wb_read(32'h0000_0480, 32'h0);

    repeat (3) @(posedge clk); // Let the last ack checks complete
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== sources.f ====
source/esp_mmio_pkg.sv
source/esp_byte_receiver.sv
source/ext_register_file.sv
source/mmio_decoder.sv
source/data_ram.sv
source/esp_mmio_top.sv
bench/tb_esp_mmio.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module tb_esp_mmio

run: build
	./obj_dir/Vtb_esp_mmio | tee sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only --timing -f sources.f --top-module tb_esp_mmio

clean:
	rm -rf obj_dir sim.log
